// ==== rv_core.f ====
source/rv_pkg.sv
source/pipe_reg.sv
source/reg_file.sv
source/decoder.sv
source/alu.sv
source/hazard_unit.sv
source/rv_core.sv
test/rv_core_checker.sv
test/rv_core_tb.sv

// ==== source/alu.sv ====
`default_nettype none
`timescale 1ns/100ps

module alu (
    input  rv_pkg::alu_op_e         op_i,
    input  logic [rv_pkg::XLEN-1:0] a_i,
    input  logic [rv_pkg::XLEN-1:0] b_i,
    input  logic [2:0]              branch_funct3_i,
    output logic [rv_pkg::XLEN-1:0] result_o,
    output logic                    branch_cond_o
);
    import rv_pkg::*;

    logic lt_s;
    logic lt_u;

    assign lt_s = $signed(a_i) < $signed(b_i);
    assign lt_u = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << b_i[4:0];
            ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SRL:  result_o = a_i >> b_i[4:0];
            ALU_SRA:  result_o = $unsigned($signed(a_i) >>> b_i[4:0]);
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            default:  result_o = b_i;           // PASS_B for LUI
        endcase
    end

    // Branch compare on the raw register operands
    always_comb begin
        case (branch_funct3_i)
            3'b000:  branch_cond_o = (a_i == b_i);
            3'b001:  branch_cond_o = (a_i != b_i);
            3'b100:  branch_cond_o = lt_s;
            3'b101:  branch_cond_o = !lt_s;
            3'b110:  branch_cond_o = lt_u;
            3'b111:  branch_cond_o = !lt_u;
            default: branch_cond_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/decoder.sv ====
`default_nettype none
`timescale 1ns/100ps

module decoder (
    input  logic [rv_pkg::XLEN-1:0] instr_i,
    output rv_pkg::id_ex_t          id_ctrl_o   // Data fields left zero
);
    import rv_pkg::*;

    logic [XLEN-1:0] instr;
    logic [2:0]      funct3;
    logic            alt;         // funct7 bit 5
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic f7_5,
                                        input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && f7_5) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return f7_5 ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Unknown opcodes become the canonical NOP
    always_comb begin
        case (opcode_e'(instr_i[6:0]))
            OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH,
            OP_LOAD, OP_STORE, OP_IMM, OP_REG: instr = instr_i;
            default:                           instr = NOP_INSTR;
        endcase
    end

    assign funct3 = instr[14:12];
    assign alt    = instr[30];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        id_ctrl_o               = '0;
        id_ctrl_o.rs1           = instr[19:15];
        id_ctrl_o.rs2           = instr[24:20];
        id_ctrl_o.rd            = instr[11:7];
        id_ctrl_o.branch_funct3 = funct3;
        id_ctrl_o.alu_op        = ALU_ADD;
        // Unused sources are zeroed so hazard logic ignores them
        case (opcode_e'(instr[6:0]))
            OP_REG: begin
                id_ctrl_o.alu_op    = alu_sel(funct3, alt, 1'b1);
                id_ctrl_o.reg_write = 1'b1;
            end
            OP_IMM: begin
                id_ctrl_o.rs2         = '0;
                id_ctrl_o.imm         = imm_i;
                id_ctrl_o.alu_op      = alu_sel(funct3, alt, 1'b0);
                id_ctrl_o.alu_src_imm = 1'b1;
                id_ctrl_o.reg_write   = 1'b1;
            end
            OP_LOAD: begin
                id_ctrl_o.rs2         = '0;
                id_ctrl_o.imm         = imm_i;
                id_ctrl_o.alu_src_imm = 1'b1;
                id_ctrl_o.mem_read    = 1'b1;
                id_ctrl_o.reg_write   = 1'b1;
            end
            OP_STORE: begin
                id_ctrl_o.rd          = '0;
                id_ctrl_o.imm         = imm_s;
                id_ctrl_o.alu_src_imm = 1'b1;
                id_ctrl_o.mem_write   = 1'b1;
            end
            OP_BRANCH: begin
                id_ctrl_o.rd     = '0;
                id_ctrl_o.imm    = imm_b;
                id_ctrl_o.branch = 1'b1;
            end
            OP_LUI: begin
                id_ctrl_o.rs1         = '0;
                id_ctrl_o.rs2         = '0;
                id_ctrl_o.imm         = imm_u;
                id_ctrl_o.alu_op      = ALU_PASS_B;
                id_ctrl_o.alu_src_imm = 1'b1;
                id_ctrl_o.lui         = 1'b1;
                id_ctrl_o.reg_write   = 1'b1;
            end
            OP_AUIPC: begin
                id_ctrl_o.rs1         = '0;
                id_ctrl_o.rs2         = '0;
                id_ctrl_o.imm         = imm_u;
                id_ctrl_o.op1_pc      = 1'b1;
                id_ctrl_o.alu_src_imm = 1'b1;
                id_ctrl_o.reg_write   = 1'b1;
            end
            OP_JAL: begin
                id_ctrl_o.rs1       = '0;
                id_ctrl_o.rs2       = '0;
                id_ctrl_o.imm       = imm_j;
                id_ctrl_o.jump      = 1'b1;
                id_ctrl_o.reg_write = 1'b1;
            end
            OP_JALR: begin
                id_ctrl_o.rs2       = '0;
                id_ctrl_o.imm       = imm_i;
                id_ctrl_o.jump      = 1'b1;
                id_ctrl_o.jalr      = 1'b1;
                id_ctrl_o.reg_write = 1'b1;
            end
            default: id_ctrl_o.reg_write = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/hazard_unit.sv ====
`default_nettype none
`timescale 1ns/100ps

module hazard_unit (
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] id_rs2_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rs2_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] mem_rd_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic                          ex_mem_read_i,
    input  logic                          mem_reg_write_i,
    input  logic                          wb_reg_write_i,
    input  logic                          mem_redirect_i,   // Taken branch or jump
    output logic [1:0]                    fwd_a_o,
    output logic [1:0]                    fwd_b_o,
    output logic                          stall_o,
    output logic                          flush_o
);
    import rv_pkg::*;

    logic load_use;

    // Youngest producer wins, x0 never forwards
    function automatic logic [1:0] fwd_sel(input logic [REG_ADDR_W-1:0] src,
                                           input logic [REG_ADDR_W-1:0] m_rd,
                                           input logic                  m_we,
                                           input logic [REG_ADDR_W-1:0] w_rd,
                                           input logic                  w_we);
        if (src == '0)                  return 2'd0;
        else if (m_we && (m_rd == src)) return 2'd1;
        else if (w_we && (w_rd == src)) return 2'd2;
        else                            return 2'd0;
    endfunction

    always_comb begin
        fwd_a_o = fwd_sel(ex_rs1_i, mem_rd_i, mem_reg_write_i, wb_rd_i, wb_reg_write_i);
        fwd_b_o = fwd_sel(ex_rs2_i, mem_rd_i, mem_reg_write_i, wb_rd_i, wb_reg_write_i);
    end

    // Load result is not ready until write-back
    assign load_use = ex_mem_read_i && (ex_rd_i != '0) &&
                      ((ex_rd_i == id_rs1_i) || (ex_rd_i == id_rs2_i));

    assign flush_o = mem_redirect_i;
    assign stall_o = load_use && !mem_redirect_i;   // Redirect kills the load-use pair

endmodule

`default_nettype wire

// ==== source/pipe_reg.sv ====
`default_nettype none
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
)(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     enable_i,
    input  logic     clear_i,     // Insert bubble, beats enable
    input  payload_t data_i,
    output payload_t data_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            data_o <= '0;         // All-zero payload means valid low
        end else if (enable_i) begin
            data_o <= data_i;
        end
    end

    // Stage contents must be fully known once the core runs
    a_known_after_reset: assert property (
        @(posedge clk_i) $rose(rst_n_i) |=> !$isunknown(data_o)
    );

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
`default_nettype none
`timescale 1ns/100ps

module reg_file (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [rv_pkg::XLEN-1:0]       rdata1_o,
    output logic [rv_pkg::XLEN-1:0]       rdata2_o,
    input  logic                          we_i,
    input  logic [rv_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [rv_pkg::XLEN-1:0]       wdata_i
);
    import rv_pkg::*;

    logic [XLEN-1:0] regs [1:31];    // x0 has no storage

    // No writes while reset is held
    always_ff @(posedge clk_i) begin
        if (rst_n_i && we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-through covers the decode read in the write-back cycle
    always_comb begin
        if (raddr1_i == '0)                          rdata1_o = '0;
        else if (we_i && (waddr_i == raddr1_i))      rdata1_o = wdata_i;
        else                                         rdata1_o = regs[raddr1_i];

        if (raddr2_i == '0)                          rdata2_o = '0;
        else if (we_i && (waddr_i == raddr2_i))      rdata2_o = wdata_i;
        else                                         rdata2_o = regs[raddr2_i];
    end

endmodule

`default_nettype wire

// ==== source/rv_core.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
)(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [rv_pkg::XLEN-1:0] imem_data_i,
    output logic [rv_pkg::XLEN-1:0] dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0] dmem_wdata_o,
    output logic                    dmem_we_o,
    output logic                    dmem_re_o,
    input  logic [rv_pkg::XLEN-1:0] dmem_rdata_i
);
    import rv_pkg::*;

    if_id_t  if_id_d,  if_id_q;
    id_ex_t  id_ctrl,  id_ex_d,  id_ex_q;
    ex_mem_t ex_mem_d, ex_mem_q;
    mem_wb_t mem_wb_d, mem_wb_q;

    logic [XLEN-1:0] pc_q, pc_plus_4_if, pc_next;
    logic [XLEN-1:0] id_instr, rs1_rdata, rs2_rdata;
    logic [XLEN-1:0] fwd_rs1, fwd_rs2, alu_a, alu_b, alu_result, jump_sum;
    logic [XLEN-1:0] mem_result, wb_data;
    logic [1:0]      fwd_a, fwd_b;
    logic            branch_cond, redirect, stall, flush, wb_we;

    // ====================
    // Fetch
    // ====================

    assign pc_plus_4_if = pc_q + 32'd4;
    assign pc_next      = flush ? ex_mem_q.jump_target : pc_plus_4_if;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!stall) begin   // Stall never coincides with flush
            pc_q <= pc_next;
        end
    end

    assign imem_addr_o = pc_q;
    assign if_id_d     = '{valid: 1'b1, pc: pc_q, pc_plus_4: pc_plus_4_if, instr: imem_data_i};

    pipe_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk_i, .rst_n_i, .enable_i(!stall), .clear_i(flush),
        .data_i(if_id_d), .data_o(if_id_q)
    );

    // ====================
    // Decode
    // ====================

    assign id_instr = if_id_q.valid ? if_id_q.instr : NOP_INSTR;

    decoder u_decoder (.instr_i(id_instr), .id_ctrl_o(id_ctrl));

    reg_file u_reg_file (
        .clk_i, .rst_n_i,
        .raddr1_i(id_ctrl.rs1), .raddr2_i(id_ctrl.rs2),
        .rdata1_o(rs1_rdata),   .rdata2_o(rs2_rdata),
        .we_i(wb_we), .waddr_i(mem_wb_q.rd), .wdata_i(wb_data)
    );

    always_comb begin
        id_ex_d           = id_ctrl;
        id_ex_d.valid     = if_id_q.valid;
        id_ex_d.pc        = if_id_q.pc;
        id_ex_d.pc_plus_4 = if_id_q.pc_plus_4;
        id_ex_d.rs1_data  = rs1_rdata;
        id_ex_d.rs2_data  = rs2_rdata;
    end

    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk_i, .rst_n_i, .enable_i(1'b1), .clear_i(stall || flush),
        .data_i(id_ex_d), .data_o(id_ex_q)
    );

    // ====================
    // Execute
    // ====================

    always_comb begin
        case (fwd_a)
            2'd1:    fwd_rs1 = mem_result;
            2'd2:    fwd_rs1 = wb_data;
            default: fwd_rs1 = id_ex_q.rs1_data;
        endcase
        case (fwd_b)
            2'd1:    fwd_rs2 = mem_result;
            2'd2:    fwd_rs2 = wb_data;
            default: fwd_rs2 = id_ex_q.rs2_data;
        endcase
    end

    assign alu_a = id_ex_q.op1_pc ? id_ex_q.pc : fwd_rs1;        // AUIPC
    assign alu_b = id_ex_q.alu_src_imm ? id_ex_q.imm : fwd_rs2;

    alu u_alu (
        .op_i(id_ex_q.alu_op), .a_i(alu_a), .b_i(alu_b),
        .branch_funct3_i(id_ex_q.branch_funct3),
        .result_o(alu_result), .branch_cond_o(branch_cond)
    );

    // JALR base is rs1, everything else is PC relative
    assign jump_sum = (id_ex_q.jalr ? fwd_rs1 : id_ex_q.pc) + id_ex_q.imm;

    assign ex_mem_d = '{
        valid:        id_ex_q.valid,
        rd:           id_ex_q.rd,
        alu_result:   alu_result,
        store_data:   fwd_rs2,
        pc_plus_4:    id_ex_q.pc_plus_4,
        jump_target:  {jump_sum[XLEN-1:1], 1'b0},
        branch_taken: id_ex_q.branch && branch_cond,
        jump:         id_ex_q.jump,
        reg_write:    id_ex_q.reg_write,
        mem_read:     id_ex_q.mem_read,
        mem_write:    id_ex_q.mem_write,
        lui:          id_ex_q.lui
    };

    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk_i, .rst_n_i, .enable_i(1'b1), .clear_i(flush),
        .data_i(ex_mem_d), .data_o(ex_mem_q)
    );

    // ====================
    // Memory
    // ====================

    assign redirect     = ex_mem_q.valid && (ex_mem_q.branch_taken || ex_mem_q.jump);
    assign dmem_addr_o  = ex_mem_q.alu_result;
    assign dmem_wdata_o = ex_mem_q.store_data;
    assign dmem_we_o    = ex_mem_q.valid && ex_mem_q.mem_write;
    assign dmem_re_o    = ex_mem_q.valid && ex_mem_q.mem_read;

    // Link value for jumps, LUI immediate arrives through PASS_B
    assign mem_result = ex_mem_q.jump ? ex_mem_q.pc_plus_4 : ex_mem_q.alu_result;

    assign mem_wb_d = '{valid: ex_mem_q.valid, rd: ex_mem_q.rd, result: mem_result,
                        reg_write: ex_mem_q.reg_write, mem_read: ex_mem_q.mem_read};

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk_i, .rst_n_i, .enable_i(1'b1), .clear_i(1'b0),
        .data_i(mem_wb_d), .data_o(mem_wb_q)
    );

    // Write-back
    assign wb_data = mem_wb_q.mem_read ? dmem_rdata_i : mem_wb_q.result;
    assign wb_we   = mem_wb_q.valid && mem_wb_q.reg_write;

    hazard_unit u_hazard (
        .id_rs1_i(id_ctrl.rs1),         .id_rs2_i(id_ctrl.rs2),
        .ex_rs1_i(id_ex_q.rs1),         .ex_rs2_i(id_ex_q.rs2),
        .ex_rd_i(id_ex_q.rd),           .mem_rd_i(ex_mem_q.rd),
        .wb_rd_i(mem_wb_q.rd),          .ex_mem_read_i(id_ex_q.mem_read),
        .mem_reg_write_i(ex_mem_q.reg_write),
        .wb_reg_write_i(mem_wb_q.reg_write),
        .mem_redirect_i(redirect),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall), .flush_o(flush)
    );

    // Target is fetched the cycle after the redirect
    a_redirect_fetch: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        redirect |=> (imem_addr_o == $past(ex_mem_q.jump_target))
    );

endmodule

`default_nettype wire

// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] NOP_INSTR = 32'h0000_0013;

    // ====================
    // Encodings
    // ====================

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    // ====================
    // Stage payloads
    // ====================

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] pc_plus_4;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       pc_plus_4;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        alu_op_e               alu_op;
        logic                  alu_src_imm;    // Operand B from imm
        logic                  op1_pc;         // Operand A from PC (AUIPC)
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  branch;
        logic [2:0]            branch_funct3;
        logic                  jump;
        logic                  jalr;
        logic                  lui;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       alu_result;
        logic [XLEN-1:0]       store_data;
        logic [XLEN-1:0]       pc_plus_4;
        logic [XLEN-1:0]       jump_target;
        logic                  branch_taken;
        logic                  jump;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  lui;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       result;
        logic                  reg_write;
        logic                  mem_read;      // Take load data at write-back
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== test/rv_core_checker.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core_checker #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
)(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic [rv_pkg::XLEN-1:0] imem_addr_i,
    input  logic [rv_pkg::XLEN-1:0] dmem_addr_i,
    input  logic [rv_pkg::XLEN-1:0] dmem_wdata_i,
    input  logic                    dmem_we_i,
    input  logic                    dmem_re_i,
    input  int                      exp_count_i,
    input  logic [rv_pkg::XLEN-1:0] exp_addr_i,    // Pair for the next store
    input  logic [rv_pkg::XLEN-1:0] exp_data_i,
    output int                      store_idx_o,
    output int                      error_count_o
);

    logic release_seen;

    initial begin
        store_idx_o   = 0;
        error_count_o = 0;
        release_seen  = 1'b0;
    end

    // Idle memory strobes and the fetch address sitting at the reset vector
    task automatic check_idle(input string phase);
        if ((dmem_we_i !== 1'b0) || (dmem_re_i !== 1'b0)) begin
            $display("Fail %0t: memory strobes we=%b re=%b %s", $time, dmem_we_i, dmem_re_i,
                     phase);
            error_count_o = error_count_o + 1;
        end
        if (imem_addr_i !== RESET_PC) begin
            $display("Fail %0t: fetch address %h %s, expected %h", $time, imem_addr_i, phase,
                     RESET_PC);
            error_count_o = error_count_o + 1;
        end
    endtask

    // ====================
    // Mid-cycle sampling
    // ====================

    always @(negedge clk_i) begin
        if (!rst_n_i) begin
            check_idle("during reset");
        end else if (!release_seen) begin
            release_seen = 1'b1;
            check_idle("at reset release");
        end

        if (rst_n_i && (dmem_we_i === 1'b1)) begin
            if (store_idx_o >= exp_count_i) begin
                $display("Extra store at %0t: %h written to address %h after the last one",
                         $time, dmem_wdata_i, dmem_addr_i);
                error_count_o = error_count_o + 1;
            end else if ((dmem_addr_i !== exp_addr_i) || (dmem_wdata_i !== exp_data_i)) begin
                $display("Fail %0t: store %0d wrote %h to %h, expected %h to %h", $time,
                         store_idx_o, dmem_wdata_i, dmem_addr_i, exp_data_i, exp_addr_i);
                error_count_o = error_count_o + 1;
            end
            store_idx_o = store_idx_o + 1;
        end
    end

endmodule

`default_nettype wire

// ==== test/rv_core_patterns.txt ====
// Words 0x00-0x3F: instruction words from address 0, four per line, unused words stay NOP
// Word 0x40: expected store count, then one store per line as address and data
@00
00500093 ffd08113 002081b3 40118233  // 00 addi, addi, add, sub
002192b3 0032c333 800003b7 4023d433  // 10 sll, xor, lui, sra
0023d4b3 0013a533 0013b5b3 00646633  // 20 srl, slt, sltu, or
0ff67693 00001717 10302023 10402223  // 30 andi, auipc, sw x3, sw x4
10602423 10702623 10802823 10902a23  // 40 sw x6, x7, x8, x9
10a02c23 10b02e23 12d02023 12e02223  // 50 sw x10, x11, x13, x14
10002783 00978813 13002423 fff00f93  // 60 lw, addi on load, sw, poison value in x31
00208463 00410463 1ff02e23 12102623  // 70 beq not taken, beq taken, poison, marker
00411463 00209463 1ff02e23 12102823  // 80 bne
0070c463 0013c463 1ff02e23 12102a23  // 90 blt
0013d463 0070d463 1ff02e23 12102c23  // a0 bge
0013e463 0070e463 1ff02e23 12102e23  // b0 bltu
0070f463 0013f463 1ff02e23 14102023  // c0 bgeu
008008ef 1ff02e23 15102223 0e800993  // d0 jal x17, poison, link store, jalr base
00098967 1ff02e23 15202423 0000006f  // e0 jalr x18, poison, link store, self-jump
@40
00000013
00000100 00000007  // add
00000104 00000002  // sub
00000108 0000001b  // sll then xor
0000010c 80000000  // lui
00000110 e0000000  // sra
00000114 20000000  // srl
00000118 00000001  // slt
0000011c 00000000  // sltu
00000120 0000001b  // or then andi
00000124 00001034  // auipc
00000128 00000010  // load-use sum
0000012c 00000005  // beq marker
00000130 00000005  // bne marker
00000134 00000005  // blt marker
00000138 00000005  // bge marker
0000013c 00000005  // bltu marker
00000140 00000005  // bgeu marker
00000144 000000d4  // jal link
00000148 000000e4  // jalr link

// ==== test/rv_core_tb.sv ====
`default_nettype none
`timescale 1ns/100ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int              CLK_PERIOD    = 100;
    localparam int              DRIVE_DELAY   = 1;
    localparam int              RESET_CYCLES  = 16;
    localparam logic [XLEN-1:0] RESET_PC      = '0;
    localparam int              IMEM_WORDS    = 64;
    localparam int              DMEM_WORDS    = 256;
    localparam int              PAT_WORDS     = 128;
    localparam int              EXP_BASE      = 64;    // Store count, then address/data pairs
    localparam int              MAX_STORES    = 31;
    localparam int              STORE_TIMEOUT = 400;
    localparam int              DRAIN_CYCLES  = 40;
    localparam string           PATTERN_FILE  = "test/rv_core_patterns.txt";

    logic            clk;
    logic            rst_n;
    logic [XLEN-1:0] imem_addr, imem_data, fetch_offset;
    logic [XLEN-1:0] dmem_addr, dmem_wdata, dmem_rdata, read_word;
    logic            dmem_we, dmem_re, read_pending;
    logic [XLEN-1:0] pat_mem [0:PAT_WORDS-1];
    logic [XLEN-1:0] dmem [0:DMEM_WORDS-1];
    logic [XLEN-1:0] exp_addr, exp_data;
    int              exp_count, store_idx, pair_idx, error_count, other_failures;

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    rv_core #(.RESET_PC(RESET_PC)) u_dut (
        .clk_i(clk), .rst_n_i(rst_n),
        .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata),
        .dmem_we_o(dmem_we), .dmem_re_o(dmem_re), .dmem_rdata_i(dmem_rdata)
    );

    rv_core_checker #(.RESET_PC(RESET_PC)) u_checker (
        .clk_i(clk), .rst_n_i(rst_n), .imem_addr_i(imem_addr),
        .dmem_addr_i(dmem_addr), .dmem_wdata_i(dmem_wdata),
        .dmem_we_i(dmem_we), .dmem_re_i(dmem_re),
        .exp_count_i(exp_count), .exp_addr_i(exp_addr), .exp_data_i(exp_data),
        .store_idx_o(store_idx), .error_count_o(error_count)
    );

    // ====================
    // Memory models
    // ====================

    assign fetch_offset = imem_addr - RESET_PC;
    assign imem_data    = (fetch_offset < IMEM_WORDS * 4) ? pat_mem[fetch_offset[7:2]] : NOP_INSTR;

    assign exp_count = pat_mem[EXP_BASE];
    assign pair_idx  = EXP_BASE + 1 + 2 * store_idx;
    assign exp_addr  = (pair_idx + 1 < PAT_WORDS) ? pat_mem[pair_idx] : '0;
    assign exp_data  = (pair_idx + 1 < PAT_WORDS) ? pat_mem[pair_idx + 1] : '0;

    // Stores land mid-cycle, load data follows the next rising edge
    always @(negedge clk) begin
        if (dmem_we === 1'b1) begin
            dmem[dmem_addr[9:2]] = dmem_wdata;
        end
        read_pending = (dmem_re === 1'b1);
        read_word    = dmem[dmem_addr[9:2]];
    end

    always @(posedge clk) begin
        #DRIVE_DELAY;
        if (read_pending) begin
            dmem_rdata = read_word;
        end
    end

    task automatic load_patterns();
        for (int i = 0; i < PAT_WORDS; i++) begin
            pat_mem[i] = (i < IMEM_WORDS) ? NOP_INSTR : '0;
        end
        $readmemh(PATTERN_FILE, pat_mem);
    endtask

    task automatic fill_data_memory();
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'h5A00_0000 | (i << 2);    // Byte address of the word
        end
    endtask

    task automatic wait_for_stores();
        int waited;
        waited = 0;
        while ((store_idx < exp_count) && (waited < STORE_TIMEOUT)) begin
            @(posedge clk);
            waited++;
        end
        if (store_idx < exp_count) begin
            $display("Timed out after %0d cycles: only %0d of %0d expected stores arrived",
                     waited, store_idx, exp_count);
            other_failures++;
        end
    endtask

    // Core spins on its self-jump here, so any store now is extra
    task automatic watch_for_extra_stores();
        int waited;
        waited = 0;
        while (waited < DRAIN_CYCLES) begin
            @(posedge clk);
            waited++;
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        dmem_rdata     = '0;
        read_word      = '0;
        read_pending   = 1'b0;
        other_failures = 0;
        load_patterns();
        fill_data_memory();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;

        if ((exp_count < 1) || (exp_count > MAX_STORES)) begin
            $display("The pattern file gives %0d expected stores, which is out of range",
                     exp_count);
            other_failures++;
        end else begin
            wait_for_stores();
        end
        watch_for_extra_stores();

        $display("Closing report: %0d value errors, %0d other failures, %0d of %0d stores seen",
                 error_count, other_failures, store_idx, exp_count);
        if ((error_count == 0) && (other_failures == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
